//--- channel_timer_bank.sv
`default_nettype none

module channel_timer_bank
    import vc_arb_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  acc_0,
    input  sched_req_t                            pld_0,
    input  logic                                  acc_1,
    input  sched_req_t                            pld_1,
    output logic [NUM_CHANS-1:0][CHAN_SLOTS-1:0] chan_busy
);

    logic [1:0]                            acc;
    sched_req_t                            pld [2];
    logic [NUM_CHANS-1:0][CHAN_SLOTS-1:0] book;

    assign acc    = {acc_1, acc_0};
    assign pld[0] = pld_0;
    assign pld[1] = pld_1;

    always_comb begin
        book = '0;
        for (int c = 0; c < NUM_CHANS; c++) begin
            for (int p = 0; p < 2; p++) begin
                if (acc[p] && pld[p].opcode == OP_WRITE && pld[p].dest.loc.chan == 1'(c)) begin
                    book[c][wr_cmd_delay(pld[p].dir)] = 1'b1;   // channel busy once the cmd lands
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan_busy <= '0;
        end else begin
            for (int c = 0; c < NUM_CHANS; c++) begin
                chan_busy[c] <= (chan_busy[c] >> 1) | book[c];
            end
        end
    end

endmodule

`default_nettype wire

//--- dual_grant_rr_arb.sv
`default_nettype none

module dual_grant_rr_arb
    import vc_arb_pkg::*;
#(
    parameter int unsigned REQ_NUM = 7
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [REQ_NUM-1:0] req_vld,
    input  sched_req_t         req_pld [REQ_NUM],
    output logic [REQ_NUM-1:0] req_rdy,
    output logic               grant_vld_0,
    output sched_req_t         grant_pld_0,
    output logic               grant_vld_1,
    output sched_req_t         grant_pld_1,
    input  logic [1:0]         grant_rdy
);

    localparam int unsigned PTR_W = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

    logic [PTR_W-1:0] ptr;                          // highest priority requester
    logic             hit_0;
    logic             hit_1;
    logic [PTR_W-1:0] idx_0;
    logic [PTR_W-1:0] idx_1;
    logic             acc_0;
    logic             acc_1;

    function automatic logic [PTR_W-1:0] next_idx(input logic [PTR_W-1:0] idx);
        return (idx == PTR_W'(REQ_NUM - 1)) ? '0 : idx + 1'b1;
    endfunction

    // walk once around from ptr, take the first two valid
    always_comb begin : search
        logic [PTR_W-1:0] idx;

        hit_0 = 1'b0;
        hit_1 = 1'b0;
        idx_0 = '0;
        idx_1 = '0;
        idx   = ptr;
        for (int k = 0; k < REQ_NUM; k++) begin
            if (req_vld[idx]) begin
                if (!hit_0) begin
                    hit_0 = 1'b1;
                    idx_0 = idx;
                end else if (!hit_1) begin
                    hit_1 = 1'b1;
                    idx_1 = idx;
                end
            end
            idx = next_idx(idx);
        end
    end

    assign grant_vld_0 = hit_0;
    assign grant_pld_0 = req_pld[idx_0];
    assign grant_vld_1 = hit_1;                     // only with a second valid
    assign grant_pld_1 = req_pld[idx_1];

    assign acc_0 = hit_0 && grant_rdy[0];
    assign acc_1 = hit_1 && grant_rdy[1];

    always_comb begin
        req_rdy = '0;
        if (acc_0) begin
            req_rdy[idx_0] = 1'b1;
        end
        if (acc_1) begin
            req_rdy[idx_1] = 1'b1;
        end
    end

    // port 1 holds the later requester in search order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (acc_1) begin
            ptr <= next_idx(idx_1);
        end else if (acc_0) begin
            ptr <= next_idx(idx_0);
        end
    end

endmodule

`default_nettype wire

//--- ram_timer_bank.sv
`default_nettype none

module ram_timer_bank
    import vc_arb_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                acc_0,
    input  sched_req_t                          pld_0,
    input  logic                                acc_1,
    input  sched_req_t                          pld_1,
    output logic [NUM_RAMS-1:0][RAM_SLOTS-1:0] ram_busy
);

    logic [1:0]                         acc;
    sched_req_t                         pld [2];
    logic [NUM_RAMS-1:0][RAM_SLOTS-1:0] book;

    assign acc    = {acc_1, acc_0};
    assign pld[0] = pld_0;
    assign pld[1] = pld_1;

    always_comb begin
        book = '0;
        for (int r = 0; r < NUM_RAMS; r++) begin
            for (int p = 0; p < 2; p++) begin
                // reads take no ram slot
                if (acc[p] && pld[p].opcode == OP_WRITE && pld[p].dest.idx == 3'(r)) begin
                    book[r][wr_ram_slot(pld[p].dir, pld[p].dest.loc.block)] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_busy <= '0;
        end else begin
            for (int r = 0; r < NUM_RAMS; r++) begin
                ram_busy[r] <= (ram_busy[r] >> 1) | book[r];    // bit 0 is the next cycle
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_vc_bank_sched -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- slot_conflict_mask.sv
`default_nettype none

module slot_conflict_mask
    import vc_arb_pkg::*;
#(
    parameter int unsigned RD_REQ_NUM = 3,
    parameter int unsigned WR_REQ_NUM = 4
) (
    input  logic [RD_REQ_NUM-1:0]                 rd_vld,
    input  sched_req_t                            rd_pld [RD_REQ_NUM],
    input  logic [WR_REQ_NUM-1:0]                 wr_vld,
    input  sched_req_t                            wr_pld [WR_REQ_NUM],
    input  logic [NUM_RAMS-1:0][RAM_SLOTS-1:0]    ram_busy,
    input  logic [NUM_CHANS-1:0][CHAN_SLOTS-1:0]  chan_busy,
    output logic [RD_REQ_NUM-1:0]                 rd_allowed,
    output logic [WR_REQ_NUM-1:0]                 wr_allowed
);

    // a read goes straight onto its channel next cycle, then reaches the ram
    for (genvar i = 0; i < RD_REQ_NUM; i++) begin : g_rd
        ram_idx_u dest;
        logic     chan_free;
        logic     ram_free;

        assign dest      = rd_pld[i].dest;
        assign chan_free = !chan_busy[dest.loc.chan][0];
        assign ram_free  = !ram_busy[dest.idx][rd_ram_slot(dest.loc.block)];

        assign rd_allowed[i] = rd_vld[i] && chan_free && ram_free;
    end

    // write requester i comes from direction i
    for (genvar i = 0; i < WR_REQ_NUM; i++) begin : g_wr
        localparam dir_e DIR = dir_e'(i);

        ram_idx_u dest;
        logic     chan_free;
        logic     ram_free;

        assign dest      = wr_pld[i].dest;
        assign chan_free = !chan_busy[dest.loc.chan][wr_cmd_delay(DIR)];
        assign ram_free  = !ram_busy[dest.idx][wr_ram_slot(DIR, dest.loc.block)];

        assign wr_allowed[i] = wr_vld[i] && chan_free && ram_free;
    end

endmodule

`default_nettype wire

//--- tb_sched_cases.txt
# rd_vld wr_vld grant_rdy dests(rd0 rd1 rd2 wr0..wr3) tags(rd0 rd1 rd2 wr0..wr3)
#   exp_rd_rdy exp_wr_rdy exp_gv0 exp_gv1 exp_tag0 exp_tag1
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
111 0000 11 0240000 a0a1a2b0b1b2b3 011 0000 1 1 a0 a1
100 0000 11 0240000 a0a1a2b0b1b2b3 100 0000 1 0 a2 00
# three reads held valid, grants rotate
111 0000 11 0240000 a0a1a2b0b1b2b3 011 0000 1 1 a0 a1
111 0000 11 0240000 a0a1a2b0b1b2b3 101 0000 1 1 a2 a0
111 0000 11 0240000 a0a1a2b0b1b2b3 110 0000 1 1 a1 a2
111 0000 11 0240000 a0a1a2b0b1b2b3 011 0000 1 1 a0 a1
# west write to ram 1, then reads to ram 1
000 0001 11 0001000 a0a1a2b0b1b2b3 000 0001 1 0 b0 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
001 0000 11 1000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
001 0000 11 1000000 a0a1a2b0b1b2b3 001 0000 1 0 a0 00
# east write books channel 0, west write then masked
000 0010 11 0000000 a0a1a2b0b1b2b3 000 0010 1 0 b1 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
000 0011 11 0002400 a0a1a2b0b1b2b3 000 0010 1 0 b1 00
000 0001 11 0002000 a0a1a2b0b1b2b3 000 0001 1 0 b0 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
001 0000 11 1000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
001 0000 11 1000000 a0a1a2b0b1b2b3 001 0000 1 0 a0 00
# back-pressure on a south write to ram 5
000 0100 10 0000050 a0a1a2b0b1b2b3 000 0000 1 0 b2 00
010 0100 01 0500050 a0a1a2b0b1b2b3 010 0000 1 1 a1 b2
000 0100 11 0000050 a0a1a2b0b1b2b3 000 0100 1 0 b2 00
# two writes accepted together, then their reads
000 1001 11 0006007 a0a1a2b0b1b2b3 000 1001 1 1 b3 b0
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
011 0000 11 6700000 a0a1a2b0b1b2b3 010 0000 1 0 a1 00
001 0000 11 6000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
001 0000 11 6000000 a0a1a2b0b1b2b3 001 0000 1 0 a0 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
000 0000 11 0000000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
010 0000 11 0700000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
010 0000 11 0700000 a0a1a2b0b1b2b3 000 0000 0 0 00 00
010 0000 11 0700000 a0a1a2b0b1b2b3 010 0000 1 0 a1 00

//--- tb_vc_bank_sched.sv
`default_nettype none

module tb_vc_bank_sched
    import vc_arb_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned RD_REQ_NUM   = 3;
    localparam int unsigned WR_REQ_NUM   = 4;
    localparam int unsigned REQ_NUM      = RD_REQ_NUM + WR_REQ_NUM;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned SLACK_CYCLES = 20;
    localparam string       CASE_FILE    = "tb_sched_cases.txt";

    typedef struct packed {
        logic [RD_REQ_NUM-1:0] rd_vld;
        logic [WR_REQ_NUM-1:0] wr_vld;
        logic [1:0]            grant_rdy;
        logic [4*REQ_NUM-1:0]  dests;                   // hex digit per requester with rd0 leftmost
        logic [8*REQ_NUM-1:0]  tags;
        logic [RD_REQ_NUM-1:0] exp_rd_rdy;
        logic [WR_REQ_NUM-1:0] exp_wr_rdy;
        logic                  exp_gv_0;
        logic                  exp_gv_1;
        logic [7:0]            exp_tag_0;
        logic [7:0]            exp_tag_1;
    } case_t;

    logic                  clk;
    logic                  rst_n;
    logic [RD_REQ_NUM-1:0] rd_vld;
    sched_req_t            rd_pld [RD_REQ_NUM];
    logic [RD_REQ_NUM-1:0] rd_rdy;
    logic [WR_REQ_NUM-1:0] wr_vld;
    sched_req_t            wr_pld [WR_REQ_NUM];
    logic [WR_REQ_NUM-1:0] wr_rdy;
    logic                  grant_vld_0;
    sched_req_t            grant_pld_0;
    logic                  grant_vld_1;
    sched_req_t            grant_pld_1;
    logic [1:0]            grant_rdy;

    case_t                 cases [$];
    int unsigned           cycles      = 0;
    int unsigned           cycle_limit = 0;     // set once the cases are loaded

    vc_bank_sched #(
        .RD_REQ_NUM (RD_REQ_NUM)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_vld      (rd_vld),
        .rd_pld      (rd_pld),
        .rd_rdy      (rd_rdy),
        .wr_vld      (wr_vld),
        .wr_pld      (wr_pld),
        .wr_rdy      (wr_rdy),
        .grant_vld_0 (grant_vld_0),
        .grant_pld_0 (grant_pld_0),
        .grant_vld_1 (grant_vld_1),
        .grant_pld_1 (grant_pld_1),
        .grant_rdy   (grant_rdy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "stopped by timeout");
        end
    end

    function automatic sched_req_t make_req(input op_e op, input dir_e dir,
                                            input logic [2:0] dest, input logic [7:0] tag);
        sched_req_t r;

        r.opcode   = op;
        r.dir      = dir;
        r.dest.idx = dest;
        r.tag      = tag;
        return r;
    endfunction

    function automatic logic [2:0] dest_of(input logic [4*REQ_NUM-1:0] dests, input int k);
        return dests[4*(REQ_NUM-1-k) +: 3];
    endfunction

    function automatic logic [7:0] tag_of(input logic [8*REQ_NUM-1:0] tags, input int k);
        return tags[8*(REQ_NUM-1-k) +: 8];
    endfunction

    // payload of the requester that owns this tag
    function automatic sched_req_t expected_grant(input case_t c, input logic [7:0] tag);
        sched_req_t r;

        r = '0;
        for (int k = 0; k < REQ_NUM; k++) begin
            if (tag_of(c.tags, k) == tag) begin
                if (k < RD_REQ_NUM) begin
                    r = make_req(OP_READ, DIR_WEST, dest_of(c.dests, k), tag);
                end else begin
                    r = make_req(OP_WRITE, dir_e'(k - RD_REQ_NUM), dest_of(c.dests, k), tag);
                end
            end
        end
        return r;
    endfunction

    task automatic load_cases();
        int                    fd;
        int                    n;
        string                 line;
        byte                   ch;
        case_t                 c;
        logic [RD_REQ_NUM-1:0] f_rd_vld;
        logic [WR_REQ_NUM-1:0] f_wr_vld;
        logic [1:0]            f_grant_rdy;
        logic [4*REQ_NUM-1:0]  f_dests;
        logic [8*REQ_NUM-1:0]  f_tags;
        logic [RD_REQ_NUM-1:0] f_rd_rdy;
        logic [WR_REQ_NUM-1:0] f_wr_rdy;
        logic                  f_gv_0;
        logic                  f_gv_1;
        logic [7:0]            f_tag_0;
        logic [7:0]            f_tag_1;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            $display("TEST FAILED");
            $fatal(1, "no case file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0) begin
                    continue;
                end
                ch = line.getc(0);
                if (ch == "#" || ch == "\n" || ch == "\r" || ch == " ") begin
                    continue;                       // comment or blank
                end
                n = $sscanf(line, "%b %b %b %h %h %b %b %b %b %h %h",
                            f_rd_vld, f_wr_vld, f_grant_rdy, f_dests, f_tags,
                            f_rd_rdy, f_wr_rdy, f_gv_0, f_gv_1, f_tag_0, f_tag_1);
                if (n != 11) begin
                    $display("case file line could not be parsed: %s", line);
                    $display("TEST FAILED");
                    $fatal(1, "bad case file");
                end else begin
                    c = {f_rd_vld, f_wr_vld, f_grant_rdy, f_dests, f_tags,
                         f_rd_rdy, f_wr_rdy, f_gv_0, f_gv_1, f_tag_0, f_tag_1};
                    cases.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_case(input case_t c);
        rd_vld    <= c.rd_vld;
        wr_vld    <= c.wr_vld;
        grant_rdy <= c.grant_rdy;
        for (int i = 0; i < RD_REQ_NUM; i++) begin
            rd_pld[i] <= make_req(OP_READ, DIR_WEST, dest_of(c.dests, i), tag_of(c.tags, i));
        end
        for (int i = 0; i < WR_REQ_NUM; i++) begin
            // write requester i is direction i
            wr_pld[i] <= make_req(OP_WRITE, dir_e'(i), dest_of(c.dests, RD_REQ_NUM + i),
                                  tag_of(c.tags, RD_REQ_NUM + i));
        end
    endtask

    task automatic report_mismatch(input int num, input string sig,
                                   input logic [31:0] exp_val, input logic [31:0] got_val);
        $display("mismatch at time %0t: case %0d, %s expected 0x%0h, got 0x%0h",
                 $time, num, sig, exp_val, got_val);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_case(input int num, input case_t c);
        sched_req_t exp_pld_0;
        sched_req_t exp_pld_1;

        exp_pld_0 = expected_grant(c, c.exp_tag_0);
        exp_pld_1 = expected_grant(c, c.exp_tag_1);
        assert (rd_rdy == c.exp_rd_rdy)
            else report_mismatch(num, "rd_rdy", 32'(c.exp_rd_rdy), 32'(rd_rdy));
        assert (wr_rdy == c.exp_wr_rdy)
            else report_mismatch(num, "wr_rdy", 32'(c.exp_wr_rdy), 32'(wr_rdy));
        assert (grant_vld_0 == c.exp_gv_0)
            else report_mismatch(num, "grant_vld_0", 32'(c.exp_gv_0), 32'(grant_vld_0));
        assert (grant_vld_1 == c.exp_gv_1)
            else report_mismatch(num, "grant_vld_1", 32'(c.exp_gv_1), 32'(grant_vld_1));
        if (c.exp_gv_0) begin
            assert (grant_pld_0 == exp_pld_0)
                else report_mismatch(num, "grant_pld_0", 32'(exp_pld_0), 32'(grant_pld_0));
        end
        if (c.exp_gv_1) begin
            assert (grant_pld_1 == exp_pld_1)
                else report_mismatch(num, "grant_pld_1", 32'(exp_pld_1), 32'(grant_pld_1));
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        rd_vld    = '0;
        wr_vld    = '0;
        grant_rdy = '0;
        for (int i = 0; i < RD_REQ_NUM; i++) begin
            rd_pld[i] = '0;
        end
        for (int i = 0; i < WR_REQ_NUM; i++) begin
            wr_pld[i] = '0;
        end

        load_cases();
        cycle_limit = RESET_CYCLES + cases.size() + SLACK_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        foreach (cases[n]) begin
            @(posedge clk);
            apply_case(cases[n]);
            @(negedge clk);                         // outputs settled mid cycle
            check_case(n + 1, cases[n]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vc_arb_pkg.sv
`default_nettype none

package vc_arb_pkg;

    localparam int unsigned NUM_RAMS    = 8;
    localparam int unsigned NUM_CHANS   = 2;
    localparam int unsigned CHAN_SLOTS  = 10;
    localparam int unsigned RAM_SLOTS   = 20;
    localparam int unsigned CHAN_SLOT_W = $clog2(CHAN_SLOTS);
    localparam int unsigned RAM_SLOT_W  = $clog2(RAM_SLOTS);

    typedef enum logic [1:0] {
        DIR_WEST  = 2'd0,
        DIR_EAST  = 2'd1,
        DIR_SOUTH = 2'd2,
        DIR_NORTH = 2'd3
    } dir_e;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    typedef struct packed {
        logic [1:0] block;
        logic       chan;                           // low bit of the ram index
    } ram_loc_t;

    typedef union packed {
        logic [2:0] idx;                            // flat ram 0..7
        ram_loc_t   loc;
    } ram_idx_u;

    typedef struct packed {
        op_e        opcode;
        dir_e       dir;
        ram_idx_u   dest;
        logic [7:0] tag;
    } sched_req_t;

    function automatic logic [RAM_SLOT_W-1:0] rd_ram_slot(input logic [1:0] block);
        return RAM_SLOT_W'(block) + 1'b1;
    endfunction

    function automatic logic [CHAN_SLOT_W-1:0] wr_cmd_delay(input dir_e dir);
        case (dir)
            DIR_WEST:  return 4'd2;
            DIR_EAST:  return 4'd3;
            DIR_SOUTH: return 4'd9;
            default:   return 4'd8;                 // north
        endcase
    endfunction

    function automatic logic [RAM_SLOT_W-1:0] wr_block_delay(input logic [1:0] block);
        return 5'd8 - RAM_SLOT_W'(block);
    endfunction

    // channel delay plus block delay, at most 17
    function automatic logic [RAM_SLOT_W-1:0] wr_ram_slot(input dir_e dir,
                                                          input logic [1:0] block);
        return RAM_SLOT_W'(wr_cmd_delay(dir)) + wr_block_delay(block);
    endfunction

endpackage

`default_nettype wire

//--- vc_bank_sched.sv
`default_nettype none

module vc_bank_sched
    import vc_arb_pkg::*;
#(
    parameter  int unsigned RD_REQ_NUM = 3,
    localparam int unsigned WR_REQ_NUM = 4,         // one per direction
    localparam int unsigned REQ_NUM    = RD_REQ_NUM + WR_REQ_NUM
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [RD_REQ_NUM-1:0] rd_vld,
    input  sched_req_t            rd_pld [RD_REQ_NUM],
    output logic [RD_REQ_NUM-1:0] rd_rdy,
    input  logic [WR_REQ_NUM-1:0] wr_vld,
    input  sched_req_t            wr_pld [WR_REQ_NUM],
    output logic [WR_REQ_NUM-1:0] wr_rdy,
    output logic                  grant_vld_0,
    output sched_req_t            grant_pld_0,
    output logic                  grant_vld_1,
    output sched_req_t            grant_pld_1,
    input  logic [1:0]            grant_rdy     // from sram side
);

    logic [RD_REQ_NUM-1:0]                rd_allowed;
    logic [WR_REQ_NUM-1:0]                wr_allowed;
    logic [REQ_NUM-1:0]                   all_vld;
    sched_req_t                           all_pld [REQ_NUM];
    logic [REQ_NUM-1:0]                   all_rdy;
    logic                                 acc_0;
    logic                                 acc_1;
    logic [NUM_RAMS-1:0][RAM_SLOTS-1:0]   ram_busy;
    logic [NUM_CHANS-1:0][CHAN_SLOTS-1:0] chan_busy;

    // reads take the low arbiter indices
    assign all_vld = {wr_allowed, rd_allowed};
    for (genvar i = 0; i < RD_REQ_NUM; i++) begin : g_rd_pld
        assign all_pld[i] = rd_pld[i];
    end
    for (genvar i = 0; i < WR_REQ_NUM; i++) begin : g_wr_pld
        assign all_pld[RD_REQ_NUM + i] = wr_pld[i];
    end
    assign {wr_rdy, rd_rdy} = all_rdy;

    assign acc_0 = grant_vld_0 && grant_rdy[0];
    assign acc_1 = grant_vld_1 && grant_rdy[1];

    slot_conflict_mask #(
        .RD_REQ_NUM (RD_REQ_NUM),
        .WR_REQ_NUM (WR_REQ_NUM)
    ) u_mask (
        .rd_vld     (rd_vld),
        .rd_pld     (rd_pld),
        .wr_vld     (wr_vld),
        .wr_pld     (wr_pld),
        .ram_busy   (ram_busy),
        .chan_busy  (chan_busy),
        .rd_allowed (rd_allowed),
        .wr_allowed (wr_allowed)
    );

    dual_grant_rr_arb #(
        .REQ_NUM     (REQ_NUM)
    ) u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_vld     (all_vld),
        .req_pld     (all_pld),
        .req_rdy     (all_rdy),
        .grant_vld_0 (grant_vld_0),
        .grant_pld_0 (grant_pld_0),
        .grant_vld_1 (grant_vld_1),
        .grant_pld_1 (grant_pld_1),
        .grant_rdy   (grant_rdy)
    );

    ram_timer_bank u_ram_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_0    (acc_0),
        .pld_0    (grant_pld_0),
        .acc_1    (acc_1),
        .pld_1    (grant_pld_1),
        .ram_busy (ram_busy)
    );

    channel_timer_bank u_chan_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_0     (acc_0),
        .pld_0     (grant_pld_0),
        .acc_1     (acc_1),
        .pld_1     (grant_pld_1),
        .chan_busy (chan_busy)
    );

endmodule

`default_nettype wire

//--- vlog.f
vc_arb_pkg.sv
ram_timer_bank.sv
channel_timer_bank.sv
slot_conflict_mask.sv
dual_grant_rr_arb.sv
vc_bank_sched.sv
tb_vc_bank_sched.sv
